//--- hdl/result_arbiter.sv
`timescale 1ns/1ps

module result_arbiter (
  input logic         clk,
  input logic         reset,
  sqrt_stream_if.sink  eng [sqrt_pkg::num_engines],
  sqrt_stream_if.source bus
);

  logic [sqrt_pkg::bit_width-1:0] msg_arr [sqrt_pkg::num_engines];
  logic [sqrt_pkg::tag_width-1:0] tag_arr [sqrt_pkg::num_engines];
  logic [sqrt_pkg::num_engines-1:0] val_vec;

  logic [sqrt_pkg::eng_width-1:0] grant;
  logic [sqrt_pkg::eng_width-1:0] grant_next;
  logic                           xfer;

  // ==================================================
  // engine side
  // ==================================================
  for (genvar i = 0; i < sqrt_pkg::num_engines; i++) begin : g_eng
    assign msg_arr[i] = eng[i].msg;
    assign tag_arr[i] = eng[i].tag;
    assign val_vec[i] = eng[i].val;
    // only the granted engine sees the bus ready
    assign eng[i].rdy = bus.rdy && (grant == i);
  end

  // ==================================================
  // shared bus
  // ==================================================
  assign bus.msg = msg_arr[grant];
  assign bus.tag = tag_arr[grant];
  assign bus.val = val_vec[grant];

  assign xfer = bus.val && bus.rdy;

  assign grant_next = (grant == sqrt_pkg::num_engines - 1) ? '0 : grant + 1'b1;

  // hold while a result waits, rotate after a transfer or when idle
  always_ff @(posedge clk) begin
    if (reset) begin
      grant <= '0;
    end else if (xfer || !val_vec[grant]) begin
      grant <= grant_next;
    end
  end

endmodule

//--- hdl/sqrt_cluster.sv
`timescale 1ns/1ps

module sqrt_cluster (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [sqrt_pkg::bit_width-1:0] recv_msg,
  input  logic [sqrt_pkg::tag_width-1:0] recv_tag,
  input  logic                           recv_val,
  output logic                           recv_rdy,
  output logic [sqrt_pkg::bit_width-1:0] send_msg,
  output logic [sqrt_pkg::tag_width-1:0] send_tag,
  output logic                           send_val,
  input  logic                           send_rdy
);

  // dispatcher to engines, engines to arbiter, arbiter to output
  sqrt_stream_if eng_in  [sqrt_pkg::num_engines] ();
  sqrt_stream_if eng_out [sqrt_pkg::num_engines] ();
  sqrt_stream_if send_bus ();

  sqrt_dispatch u_dispatch (
    .clk      (clk),
    .reset    (reset),
    .recv_msg (recv_msg),
    .recv_tag (recv_tag),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .eng      (eng_in)
  );

  for (genvar i = 0; i < sqrt_pkg::num_engines; i++) begin : g_engine
    sqrt_engine u_engine (
      .clk   (clk),
      .reset (reset),
      .in    (eng_in[i]),
      .out   (eng_out[i])
    );
  end

  result_arbiter u_arbiter (
    .clk   (clk),
    .reset (reset),
    .eng   (eng_out),
    .bus   (send_bus)
  );

  assign send_msg     = send_bus.msg;
  assign send_tag     = send_bus.tag;
  assign send_val     = send_bus.val;
  assign send_bus.rdy = send_rdy;

endmodule

//--- hdl/sqrt_control.sv
`timescale 1ns/1ps

module sqrt_control (
  input  logic clk,
  input  logic reset,
  input  logic in_val,
  input  logic out_rdy,
  input  logic step_neg,
  output logic in_rdy,
  output logic out_val,
  output logic load,
  output logic step
);

  sqrt_pkg::sqrt_state_e state;
  sqrt_pkg::sqrt_state_e state_next;

  // counts completed steps in calc
  logic [sqrt_pkg::cnt_width-1:0] cnt;
  logic                           last_step;

  // step_neg only steers the datapath mux, the step count is fixed

  assign last_step = (cnt == (sqrt_pkg::iter - 1));

  // ==================================================
  // next state
  // ==================================================
  always_comb begin
    state_next = state;
    case (state)
      sqrt_pkg::idle: begin
        if (in_val) begin
          state_next = sqrt_pkg::calc;
        end
      end
      sqrt_pkg::calc: begin
        if (last_step) begin
          state_next = sqrt_pkg::done;
        end
      end
      sqrt_pkg::done: begin
        // leave once the arbiter takes the result
        if (out_rdy) begin
          state_next = sqrt_pkg::idle;
        end
      end
      default: begin
        state_next = sqrt_pkg::idle;
      end
    endcase
  end

  // ==================================================
  // state and counter
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sqrt_pkg::idle;
      cnt   <= '0;
    end else begin
      state <= state_next;
      if (state == sqrt_pkg::calc) begin
        cnt <= cnt + 1'b1;
      end else begin
        cnt <= '0;
      end
    end
  end

  // handshake and datapath strobes
  assign in_rdy  = (state == sqrt_pkg::idle);
  assign out_val = (state == sqrt_pkg::done);
  assign load    = in_rdy && in_val;
  assign step    = (state == sqrt_pkg::calc);

endmodule

//--- hdl/sqrt_datapath.sv
`timescale 1ns/1ps

module sqrt_datapath (
  input  logic                           clk,
  input  logic                           load,
  input  logic                           step,
  input  logic [sqrt_pkg::bit_width-1:0] radicand,
  output logic                           step_neg,
  output logic [sqrt_pkg::bit_width-1:0] root
);

  // radicand bits not yet consumed, top pair first
  logic [sqrt_pkg::bit_width-1:0] x;
  // partial root
  logic [sqrt_pkg::bit_width-1:0] q;
  // partial remainder, two bits wider than the radicand
  logic [sqrt_pkg::bit_width+1:0] ac;

  logic [sqrt_pkg::bit_width+1:0] ac_shift;
  logic [sqrt_pkg::bit_width+1:0] trial;

  // ==================================================
  // trial subtract
  // ==================================================

  // bring down the next two radicand bits
  assign ac_shift = {ac[sqrt_pkg::bit_width-1:0], x[sqrt_pkg::bit_width-1 -: 2]};

  // subtract 4q + 1
  assign trial = ac_shift - {q, 2'b01};

  // msb set means the trial went negative
  assign step_neg = trial[sqrt_pkg::bit_width+1];

  // ==================================================
  // registers
  // ==================================================
  always_ff @(posedge clk) begin
    if (load) begin
      x  <= radicand;
      q  <= '0;
      ac <= '0;
    end else if (step) begin
      x <= {x[sqrt_pkg::bit_width-3:0], 2'b00};
      if (step_neg) begin
        // trial failed, keep the shifted remainder
        ac <= ac_shift;
        q  <= {q[sqrt_pkg::bit_width-2:0], 1'b0};
      end else begin
        ac <= trial;
        q  <= {q[sqrt_pkg::bit_width-2:0], 1'b1};
      end
    end
  end

  // upper half stays zero after iter steps
  assign root = q;

endmodule

//--- hdl/sqrt_dispatch.sv
`timescale 1ns/1ps

module sqrt_dispatch (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [sqrt_pkg::bit_width-1:0] recv_msg,
  input  logic [sqrt_pkg::tag_width-1:0] recv_tag,
  input  logic                           recv_val,
  output logic                           recv_rdy,
  sqrt_stream_if.source                  eng [sqrt_pkg::num_engines]
);

  logic [sqrt_pkg::num_engines-1:0] rdy_vec;

  // engine preferred for the next load
  logic [sqrt_pkg::eng_width-1:0] ptr;
  logic [sqrt_pkg::eng_width-1:0] sel;
  logic [sqrt_pkg::eng_width-1:0] cand;
  logic                           found;

  // fan out payload, steer val to one engine
  for (genvar i = 0; i < sqrt_pkg::num_engines; i++) begin : g_eng
    assign rdy_vec[i] = eng[i].rdy;
    assign eng[i].msg = recv_msg;
    assign eng[i].tag = recv_tag;
    assign eng[i].val = recv_val && found && (sel == i);
  end

  // first ready engine, searching from ptr
  always_comb begin
    found = 1'b0;
    sel   = ptr;
    cand  = ptr;
    for (int k = 0; k < sqrt_pkg::num_engines; k++) begin
      if (!found && rdy_vec[cand]) begin
        found = 1'b1;
        sel   = cand;
      end
      if (cand == sqrt_pkg::num_engines - 1) begin
        cand = '0;
      end else begin
        cand = cand + 1'b1;
      end
    end
  end

  assign recv_rdy = found;

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (recv_val && found) begin
      ptr <= (sel == sqrt_pkg::num_engines - 1) ? '0 : sel + 1'b1;
    end
  end

endmodule

//--- hdl/sqrt_engine.sv
`timescale 1ns/1ps

module sqrt_engine (
  input logic          clk,
  input logic          reset,
  sqrt_stream_if.sink   in,
  sqrt_stream_if.source out
);

  logic load;
  logic step;
  logic step_neg;

  // tag rides along with the item in flight
  logic [sqrt_pkg::tag_width-1:0] tag_q;

  sqrt_datapath u_dpath (
    .clk      (clk),
    .load     (load),
    .step     (step),
    .radicand (in.msg),
    .step_neg (step_neg),
    .root     (out.msg)
  );

  sqrt_control u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .in_val   (in.val),
    .out_rdy  (out.rdy),
    .step_neg (step_neg),
    .in_rdy   (in.rdy),
    .out_val  (out.val),
    .load     (load),
    .step     (step)
  );

  always_ff @(posedge clk) begin
    if (load) begin
      tag_q <= in.tag;
    end
  end

  assign out.tag = tag_q;

endmodule

//--- hdl/sqrt_pkg.sv
package sqrt_pkg;

  // ==================================================
  // widths and counts
  // ==================================================

  // radicand width, root port has the same width
  localparam int bit_width = 16;

  // one iteration per root bit
  localparam int iter = bit_width / 2;
  localparam int cnt_width = $clog2(iter);

  localparam int tag_width = 4;

  localparam int num_engines = 2;
  // index width for engine pointers and grants
  localparam int eng_width = (num_engines > 1) ? $clog2(num_engines) : 1;

  // ==================================================
  // engine controller states
  // ==================================================
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } sqrt_state_e;

endpackage

//--- hdl/sqrt_stream_if.sv
`timescale 1ns/1ps

// one valid/ready stream carrying a value and its tag
interface sqrt_stream_if;

  // radicand on the way in, root on the way out
  logic [sqrt_pkg::bit_width-1:0] msg;
  logic [sqrt_pkg::tag_width-1:0] tag;
  logic                           val;
  logic                           rdy;

  modport source (
    output msg,
    output tag,
    output val,
    input  rdy
  );

  modport sink (
    input  msg,
    input  tag,
    input  val,
    output rdy
  );

endinterface

//--- sqrt_cluster.f
hdl/sqrt_pkg.sv
hdl/sqrt_stream_if.sv
hdl/sqrt_datapath.sv
hdl/sqrt_control.sv
hdl/sqrt_engine.sv
hdl/sqrt_dispatch.sv
hdl/result_arbiter.sv
hdl/sqrt_cluster.sv
verification/tb_clock.sv
verification/sqrt_checker.sv
verification/sqrt_cluster_tb.sv

//--- verification/sqrt_checker.sv
`timescale 1ns/1ps

module sqrt_checker (
  input logic                           clk,
  input logic                           reset,
  input logic [sqrt_pkg::bit_width-1:0] recv_msg,
  input logic [sqrt_pkg::tag_width-1:0] recv_tag,
  input logic                           recv_val,
  input logic                           recv_rdy,
  input logic [sqrt_pkg::bit_width-1:0] send_msg,
  input logic [sqrt_pkg::tag_width-1:0] send_tag,
  input logic                           send_val,
  input logic                           send_rdy
);

  localparam int num_tags = 1 << sqrt_pkg::tag_width;

  string test_name = "none";
  int    errors    = 0;
  int    pending   = 0;

  // expected roots by tag
  logic [sqrt_pkg::bit_width-1:0] exp_root [num_tags];
  logic                           pend     [num_tags];

  // result stalled by send_rdy on the previous edge
  logic                           held;
  logic [sqrt_pkg::bit_width-1:0] held_msg;
  logic [sqrt_pkg::tag_width-1:0] held_tag;

  // largest r with r*r not above x
  function automatic int ref_root(input int x);
    int r;
    r = 0;
    while ((r + 1) * (r + 1) <= x) begin
      r = r + 1;
    end
    return r;
  endfunction

  // ==================================================
  // compare on every transfer edge
  // ==================================================
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_tags; i++) begin
        pend[i] = 1'b0;
      end
      pending = 0;
      held    = 1'b0;
    end else begin
      if (held && (!send_val || send_msg !== held_msg || send_tag !== held_tag)) begin
        $display("%s: result changed or dropped while send_rdy was low", test_name);
        errors++;
      end
      held     = send_val && !send_rdy;
      held_msg = send_msg;
      held_tag = send_tag;

      if (!recv_rdy && pending != sqrt_pkg::num_engines) begin
        $display("%s: recv_rdy low with only %0d items pending", test_name, pending);
        errors++;
      end

      if (send_val && send_rdy) begin
        if (!pend[send_tag]) begin
          $display("%s: result with tag %0d has no pending radicand", test_name, send_tag);
          errors++;
        end else begin
          if (send_msg !== exp_root[send_tag]) begin
            $display("Fail %s: tag %0d expected %0d actual %0d",
                     test_name, send_tag, exp_root[send_tag], send_msg);
            errors++;
          end
          pend[send_tag] = 1'b0;
          pending--;
        end
      end

      if (recv_val && recv_rdy) begin
        if (pend[recv_tag]) begin
          $display("%s: tag %0d reused while still pending", test_name, recv_tag);
          errors++;
        end else begin
          pending++;
        end
        pend[recv_tag]     = 1'b1;
        exp_root[recv_tag] = ref_root(int'(recv_msg));
      end
    end
  end

endmodule

//--- verification/sqrt_cluster_tb.sv
`timescale 1ns/1ps

module sqrt_cluster_tb;

  localparam int num_directed = 15;
  localparam int num_random   = 200;
  localparam int num_bp       = 100;
  localparam int total_items  = num_directed + num_random + num_bp + 2;
  localparam int item_cycles  = sqrt_pkg::iter + 20;
  localparam int drain_limit  = 4 * item_cycles;

  logic                           clk;
  logic                           reset;
  logic [sqrt_pkg::bit_width-1:0] recv_msg;
  logic [sqrt_pkg::tag_width-1:0] recv_tag;
  logic                           recv_val;
  logic                           recv_rdy;
  logic [sqrt_pkg::bit_width-1:0] send_msg;
  logic [sqrt_pkg::tag_width-1:0] send_tag;
  logic                           send_val;
  logic                           send_rdy;

  integer seed = 32'h159c_6945;
  logic   bp_on;
  int     tb_errors;
  int     err_mark;
  int     tests_passed;
  int     tests_failed;
  int     rand_root;
  int     directed [10] = '{0, 1, 2, 3, 4, 15, 16, 255, 256, 65535};

  tb_clock u_clock (.clk(clk));

  sqrt_cluster u_dut (
    .clk(clk), .reset(reset),
    .recv_msg(recv_msg), .recv_tag(recv_tag), .recv_val(recv_val), .recv_rdy(recv_rdy),
    .send_msg(send_msg), .send_tag(send_tag), .send_val(send_val), .send_rdy(send_rdy)
  );

  sqrt_checker u_check (
    .clk(clk), .reset(reset),
    .recv_msg(recv_msg), .recv_tag(recv_tag), .recv_val(recv_val), .recv_rdy(recv_rdy),
    .send_msg(send_msg), .send_tag(send_tag), .send_val(send_val), .send_rdy(send_rdy)
  );

  // random back-pressure on the output
  always @(negedge clk) begin
    if (bp_on) begin
      send_rdy = $random(seed) & 1;
    end
  end

  task automatic start_test(input string name);
    u_check.test_name = name;
    err_mark = u_check.errors + tb_errors;
  endtask

  task automatic end_test(input string name);
    int n;
    n = u_check.errors + tb_errors - err_mark;
    if (n == 0) begin
      $display("test %s finished: ok", name);
      tests_passed++;
    end else begin
      $display("test %s finished: %0d errors", name, n);
      tests_failed++;
    end
  endtask

  // called at a falling edge, returns at the falling edge after the transfer
  task automatic send_item(input logic [sqrt_pkg::bit_width-1:0] msg);
    recv_msg = msg;
    recv_val = 1'b1;
    @(posedge clk);
    while (!recv_rdy) begin
      @(posedge clk);
    end
    @(negedge clk);
    recv_tag = recv_tag + 1'b1;
  endtask

  task automatic drain();
    int n;
    n = 0;
    recv_val = 1'b0;
    while (u_check.pending != 0 && n < drain_limit) begin
      @(negedge clk);
      n++;
    end
    if (u_check.pending != 0) begin
      $display("%s: %0d results never came back", u_check.test_name, u_check.pending);
      tb_errors++;
    end
  endtask

  // ==================================================
  // tests
  // ==================================================
  initial begin
    reset = 1'b1;
    recv_msg = '0;
    recv_tag = '0;
    recv_val = 1'b0;
    send_rdy = 1'b1;
    bp_on = 1'b0;
    tb_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    rand_root = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    start_test("reset_state");
    repeat (5) begin
      @(negedge clk);
      if (send_val !== 1'b0 || recv_rdy !== 1'b1) begin
        $display("reset_state: send_val or recv_rdy wrong after reset");
        tb_errors++;
      end
    end
    end_test("reset_state");

    start_test("directed");
    for (int i = 0; i < num_directed; i++) begin
      if (i < 10) begin
        send_item(directed[i]);
      end else begin
        // perfect square of a random 8-bit root
        rand_root = $random(seed) & 8'hff;
        send_item(rand_root * rand_root);
      end
      drain();
    end
    end_test("directed");

    start_test("random_stream");
    for (int i = 0; i < num_random; i++) begin
      send_item($random(seed));
    end
    drain();
    end_test("random_stream");

    start_test("back_pressure");
    bp_on = 1'b1;
    for (int i = 0; i < num_bp; i++) begin
      send_item($random(seed));
    end
    bp_on = 1'b0;
    send_rdy = 1'b1;
    drain();
    end_test("back_pressure");

    // both engines loaded while the output is blocked
    start_test("parallel_engines");
    send_rdy = 1'b0;
    for (int i = 0; i < 2; i++) begin
      if (recv_rdy !== 1'b1) begin
        $display("parallel_engines: recv_rdy low before both engines were loaded");
        tb_errors++;
      end
      send_item($random(seed));
    end
    recv_val = 1'b0;
    repeat (sqrt_pkg::iter + 3) begin
      if (recv_rdy !== 1'b0) begin
        $display("parallel_engines: recv_rdy high with both engines busy");
        tb_errors++;
      end
      @(negedge clk);
    end
    send_rdy = 1'b1;
    drain();
    end_test("parallel_engines");

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && u_check.errors + tb_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog sized from the item count
  initial begin
    repeat (total_items * item_cycles + 50) @(posedge clk);
    $display("timeout: the tests did not finish in time");
    $display("Something failed");
    $finish;
  end

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // half of the 100 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

endmodule
